//--- common/lstm_macros.svh
// widths, vector length and fraction bits of the lstm cell
`ifndef LSTM_MACROS_SVH
`define LSTM_MACROS_SVH

// data word, signed q4.12
`define LSTM_WIDTH 16
`define LSTM_FRAC 12

// samples per sequence step
`define LSTM_NUM_IN 4

// full-scale products and sums
`define LSTM_ACC_WIDTH 32

// sample weights, recurrent weight and bias per row
`define LSTM_ADDR_WIDTH ($clog2(`LSTM_NUM_IN + 2))

`endif

//--- common/lstm_pkg.sv
// gate and sequencer enums, fixed-point types and constants, hard tanh
`include "lstm_macros.svh"

package lstm_pkg;

	////////////////////
	// enums
	////////////////////

	// weight row select
	typedef enum logic [1:0]
	{
		GATE_A,
		GATE_I,
		GATE_F,
		GATE_O
	} gate_e;

	// weight bank sequencer
	typedef enum logic [1:0]
	{
		SEQ_IDLE,
		SEQ_SAMPLES,
		SEQ_RECUR
	} seq_state_e;

	////////////////////
	// fixed point
	////////////////////

	typedef logic signed [`LSTM_WIDTH-1:0] fix_t;
	typedef logic signed [`LSTM_ACC_WIDTH-1:0] acc_t;

	localparam fix_t ONE_FIX = 16'sd4096;
	localparam fix_t HALF_FIX = 16'sd2048;

	// clamp to +-1.0, input already in q4.12 scale
	function automatic fix_t hard_tanh(input acc_t v);
		if (v > acc_t'(ONE_FIX))
			return ONE_FIX;
		else if (v < -acc_t'(ONE_FIX))
			return -ONE_FIX;
		else
			return fix_t'(v);
	endfunction

endpackage

//--- common/lstm_elem_if.sv
// interface for one sample and its four gate weights and biases
`timescale 1ns/10ps
`include "lstm_macros.svh"

interface lstm_elem_if
	import lstm_pkg::*;
	();

	logic valid;
	logic first;
	logic last;
	fix_t x;
	fix_t w_a;
	fix_t w_i;
	fix_t w_f;
	fix_t w_o;
	// biases only matter with first
	fix_t b_a;
	fix_t b_i;
	fix_t b_f;
	fix_t b_o;

	modport source
	(
		output valid, first, last, x,
		output w_a, w_i, w_f, w_o,
		output b_a, b_i, b_f, b_o
	);

	modport sink
	(
		input valid, first, last, x,
		input w_a, w_i, w_f, w_o,
		input b_a, b_i, b_f, b_o
	);

endinterface

//--- hw/weight_bank.sv
// gate weight storage, element sequencer and recurrent element insertion
`timescale 1ns/10ps
`include "lstm_macros.svh"

module weight_bank
	import lstm_pkg::*;
	(
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_wr,
	input  gate_e                       i_wr_gate,
	input  logic [`LSTM_ADDR_WIDTH-1:0] i_wr_addr,
	input  fix_t                        i_wr_data,
	input  logic                        i_x_valid,
	input  logic                        i_x_last,
	input  fix_t                        i_x,
	input  fix_t                        i_h_prev,
	lstm_elem_if.source                 elem
	);

	localparam int ENTRIES = `LSTM_NUM_IN + 2;
	localparam logic [`LSTM_ADDR_WIDTH-1:0] RECUR_ADDR = (`LSTM_ADDR_WIDTH)'(`LSTM_NUM_IN);
	localparam logic [`LSTM_ADDR_WIDTH-1:0] BIAS_ADDR = (`LSTM_ADDR_WIDTH)'(`LSTM_NUM_IN + 1);

	fix_t w_mem [4][ENTRIES];
	seq_state_e state;
	logic [`LSTM_ADDR_WIDTH-1:0] cnt;
	logic [`LSTM_ADDR_WIDTH-1:0] rd_addr;

	// writes only land while idle
	always_ff @(posedge i_clk)
	begin
		if (i_wr && state == SEQ_IDLE && i_wr_addr < ENTRIES)
			w_mem[i_wr_gate][i_wr_addr] <= i_wr_data;
	end

	assign rd_addr = (state == SEQ_RECUR) ? RECUR_ADDR : cnt;

	////////////////////
	// sequencer
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			state <= SEQ_IDLE;
			cnt <= '0;
			elem.valid <= 1'b0;
			elem.first <= 1'b0;
			elem.last <= 1'b0;
		end
		else
		begin
			elem.valid <= i_x_valid || (state == SEQ_RECUR);
			elem.first <= i_x_valid && (state == SEQ_IDLE);
			elem.last <= (state == SEQ_RECUR);
			case (state)
				SEQ_IDLE, SEQ_SAMPLES:
				begin
					if (i_x_valid)
					begin
						cnt <= cnt + 1'b1;
						state <= i_x_last ? SEQ_RECUR : SEQ_SAMPLES;
					end
				end
				SEQ_RECUR:
				begin
					// h element goes out now, back to idle
					cnt <= '0;
					state <= SEQ_IDLE;
				end
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

	// element payload
	always_ff @(posedge i_clk)
	begin
		elem.x <= (state == SEQ_RECUR) ? i_h_prev : i_x;
		elem.w_a <= w_mem[GATE_A][rd_addr];
		elem.w_i <= w_mem[GATE_I][rd_addr];
		elem.w_f <= w_mem[GATE_F][rd_addr];
		elem.w_o <= w_mem[GATE_O][rd_addr];
		elem.b_a <= w_mem[GATE_A][BIAS_ADDR];
		elem.b_i <= w_mem[GATE_I][BIAS_ADDR];
		elem.b_f <= w_mem[GATE_F][BIAS_ADDR];
		elem.b_o <= w_mem[GATE_O][BIAS_ADDR];
	end

	////////////////////
	// assertions
	////////////////////

	a_wr_idle: assert property (@(posedge i_clk) disable iff (i_rst)
		i_wr |-> state == SEQ_IDLE);

	// the h slot needs the cycle after i_x_last to itself
	a_no_sample_recur: assert property (@(posedge i_clk) disable iff (i_rst)
		state == SEQ_RECUR |-> !i_x_valid);

endmodule

//--- lstm_core/gate_mac.sv
// four parallel gate multiply-accumulators with bias seeding
`timescale 1ns/10ps
`include "lstm_macros.svh"

module gate_mac
	import lstm_pkg::*;
	(
	input  logic      i_clk,
	input  logic      i_rst,
	lstm_elem_if.sink elem,
	output logic      o_sums_valid,
	output acc_t      o_sum_a,
	output acc_t      o_sum_i,
	output acc_t      o_sum_f,
	output acc_t      o_sum_o
	);

	fix_t w [4];
	fix_t b [4];
	acc_t prod [4];
	acc_t base [4];
	acc_t acc_next [4];
	acc_t acc [4];
	acc_t sum [4];

	assign w[GATE_A] = elem.w_a;
	assign w[GATE_I] = elem.w_i;
	assign w[GATE_F] = elem.w_f;
	assign w[GATE_O] = elem.w_o;

	assign b[GATE_A] = elem.b_a;
	assign b[GATE_I] = elem.b_i;
	assign b[GATE_F] = elem.b_f;
	assign b[GATE_O] = elem.b_o;

	////////////////////
	// datapath
	////////////////////

	// sums kept at q8.24 until the last element
	always_comb
	begin
		for (int g = 0; g < 4; g++)
		begin
			prod[g] = acc_t'(elem.x) * acc_t'(w[g]);
			// bias moved up to product scale
			base[g] = elem.first ? (acc_t'(b[g]) <<< `LSTM_FRAC) : acc[g];
			acc_next[g] = base[g] + prod[g];
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (elem.valid)
		begin
			for (int g = 0; g < 4; g++)
			begin
				acc[g] <= acc_next[g];
			end
		end
		if (elem.valid && elem.last)
		begin
			// floor back to q4.12
			for (int g = 0; g < 4; g++)
			begin
				sum[g] <= acc_next[g] >>> `LSTM_FRAC;
			end
		end
	end

	// done strobe
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_sums_valid <= 1'b0;
		else
			o_sums_valid <= elem.valid && elem.last;
	end

	assign o_sum_a = sum[GATE_A];
	assign o_sum_i = sum[GATE_I];
	assign o_sum_f = sum[GATE_F];
	assign o_sum_o = sum[GATE_O];

endmodule

//--- lstm_core/gate_activation.sv
// registered hard tanh and hard sigmoid gate activations
`timescale 1ns/10ps
`include "lstm_macros.svh"

module gate_activation
	import lstm_pkg::*;
	(
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_sums_valid,
	input  acc_t i_sum_a,
	input  acc_t i_sum_i,
	input  acc_t i_sum_f,
	input  acc_t i_sum_o,
	output logic o_act_valid,
	output fix_t o_a,
	output fix_t o_i,
	output fix_t o_f,
	output fix_t o_o
	);

	// x/4 + 0.5, clamped to 0..1
	function automatic fix_t hard_sigmoid(input acc_t sum);
		acc_t t;
		t = (sum >>> 2) + acc_t'(HALF_FIX);
		if (t > acc_t'(ONE_FIX))
			return ONE_FIX;
		else if (t < 0)
			return '0;
		else
			return fix_t'(t);
	endfunction

	////////////////////
	// output registers
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_sums_valid)
		begin
			o_a <= hard_tanh(i_sum_a);
			o_i <= hard_sigmoid(i_sum_i);
			o_f <= hard_sigmoid(i_sum_f);
			o_o <= hard_sigmoid(i_sum_o);
		end
	end

	// strobe follows the data
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_act_valid <= 1'b0;
		else
			o_act_valid <= i_sums_valid;
	end

endmodule

//--- lstm_core/cell_update.sv
// cell and hidden state registers with step output strobe
`timescale 1ns/10ps
`include "lstm_macros.svh"

module cell_update
	import lstm_pkg::*;
	(
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_seq_start,
	input  logic i_act_valid,
	input  fix_t i_a,
	input  fix_t i_i,
	input  fix_t i_f,
	input  fix_t i_o,
	output fix_t o_c,
	output fix_t o_h,
	output logic o_h_valid,
	output fix_t o_h_prev
	);

	// limits of the signed data word
	localparam acc_t FIX_MAX = (acc_t'(1) <<< (`LSTM_WIDTH - 1)) - acc_t'(1);
	localparam acc_t FIX_MIN = -FIX_MAX - acc_t'(1);

	// clip a q4.12 sum into the 16 bit word
	function automatic fix_t sat_fix(input acc_t v);
		if (v > FIX_MAX)
			return fix_t'(FIX_MAX);
		else if (v < FIX_MIN)
			return fix_t'(FIX_MIN);
		else
			return fix_t'(v);
	endfunction

	fix_t c_reg;
	fix_t h_reg;
	acc_t prod_ai;
	acc_t prod_fc;
	acc_t c_sum;
	fix_t c_next;
	fix_t h_next;

	////////////////////
	// c and h datapath
	////////////////////

	always_comb
	begin
		// a*i + f*c_prev with each product floored to q4.12
		prod_ai = (acc_t'(i_a) * acc_t'(i_i)) >>> `LSTM_FRAC;
		prod_fc = (acc_t'(i_f) * acc_t'(c_reg)) >>> `LSTM_FRAC;
		c_sum = prod_ai + prod_fc;
		c_next = sat_fix(c_sum);
		// |o| and |tanh| both <= 1, so h always fits
		h_next = fix_t'((acc_t'(i_o) * acc_t'(hard_tanh(acc_t'(c_next)))) >>> `LSTM_FRAC);
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst || i_seq_start)
		begin
			c_reg <= '0;
			h_reg <= '0;
		end
		else if (i_act_valid)
		begin
			c_reg <= c_next;
			h_reg <= h_next;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_h_valid <= 1'b0;
		else
			o_h_valid <= i_act_valid;
	end

	assign o_c = c_reg;
	assign o_h = h_reg;
	// held h feeds the recurrent element of the next step
	assign o_h_prev = h_reg;

	// a new sequence must not clear state mid update
	a_start_vs_act: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_seq_start && i_act_valid));

endmodule

//--- hw/lstm_top.sv
// lstm cell top level with weight bank, gate core and cell update
`timescale 1ns/10ps
`include "lstm_macros.svh"

module lstm_top
	import lstm_pkg::*;
	(
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_seq_start,
	input  logic                        i_wr,
	input  gate_e                       i_wr_gate,
	input  logic [`LSTM_ADDR_WIDTH-1:0] i_wr_addr,
	input  fix_t                        i_wr_data,
	input  logic                        i_x_valid,
	input  logic                        i_x_last,
	input  fix_t                        i_x,
	output logic                        o_h_valid,
	output fix_t                        o_c,
	output fix_t                        o_h
	);

	lstm_elem_if elem_bus ();

	logic sums_valid;
	acc_t sum_a;
	acc_t sum_i;
	acc_t sum_f;
	acc_t sum_o;
	logic act_valid;
	fix_t act_a;
	fix_t act_i;
	fix_t act_f;
	fix_t act_o;
	fix_t h_prev;

	////////////////////
	// input side
	////////////////////

	weight_bank u_weight_bank (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_wr      (i_wr),
		.i_wr_gate (i_wr_gate),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data),
		.i_x_valid (i_x_valid),
		.i_x_last  (i_x_last),
		.i_x       (i_x),
		.i_h_prev  (h_prev),
		.elem      (elem_bus.source)
	);

	////////////////////
	// gate core
	////////////////////

	gate_mac u_gate_mac (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.elem         (elem_bus.sink),
		.o_sums_valid (sums_valid),
		.o_sum_a      (sum_a),
		.o_sum_i      (sum_i),
		.o_sum_f      (sum_f),
		.o_sum_o      (sum_o)
	);

	gate_activation u_gate_activation (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_sums_valid (sums_valid),
		.i_sum_a      (sum_a),
		.i_sum_i      (sum_i),
		.i_sum_f      (sum_f),
		.i_sum_o      (sum_o),
		.o_act_valid  (act_valid),
		.o_a          (act_a),
		.o_i          (act_i),
		.o_f          (act_f),
		.o_o          (act_o)
	);

	// output side
	cell_update u_cell_update (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_seq_start (i_seq_start),
		.i_act_valid (act_valid),
		.i_a         (act_a),
		.i_i         (act_i),
		.i_f         (act_f),
		.i_o         (act_o),
		.o_c         (o_c),
		.o_h         (o_h),
		.o_h_valid   (o_h_valid),
		.o_h_prev    (h_prev)
	);

endmodule

//--- bench/lstm_checker.sv
// reference model of the lstm cell, latency tracking and comparison of dut outputs
`timescale 1ns/10ps
`include "lstm_macros.svh"

module lstm_checker
	import lstm_pkg::*;
	(
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_seq_start,
	input  logic                        i_wr,
	input  gate_e                       i_wr_gate,
	input  logic [`LSTM_ADDR_WIDTH-1:0] i_wr_addr,
	input  fix_t                        i_wr_data,
	input  logic                        i_x_valid,
	input  logic                        i_x_last,
	input  fix_t                        i_x,
	input  logic                        i_h_valid,
	input  fix_t                        i_c,
	input  fix_t                        i_h,
	output int                          o_pass_cnt,
	output int                          o_fail_cnt
	);

	localparam int ENTRIES = `LSTM_NUM_IN + 2;
	localparam int LATENCY = 5;
	localparam longint ONE = 64'sd1 <<< `LSTM_FRAC;

	longint wm [4][ENTRIES];
	longint xs [`LSTM_NUM_IN];
	longint c_m;
	longint h_m;
	longint exp_c;
	longint exp_h;
	int n_x;
	int wait_cnt;
	int step_no;
	logic busy;

	function automatic longint clamp(input longint v, input longint lo, input longint hi);
		if (v > hi)
			return hi;
		else if (v < lo)
			return lo;
		else
			return v;
	endfunction

	// product of two q4.12 values, floored back to q4.12
	function automatic longint floor_mul(input longint a, input longint b);
		return (a * b) >>> `LSTM_FRAC;
	endfunction

	////////////////////
	// cell model
	////////////////////

	task automatic predict_step();
		longint acc;
		longint sum [4];
		longint a;
		longint ig;
		longint fg;
		longint og;
		for (int g = 0; g < 4; g++)
		begin
			acc = wm[g][ENTRIES-1] <<< `LSTM_FRAC;
			for (int k = 0; k < n_x; k++)
				acc = acc + xs[k] * wm[g][k];
			// recurrent element with the held h
			acc = acc + h_m * wm[g][`LSTM_NUM_IN];
			sum[g] = acc >>> `LSTM_FRAC;
		end
		a = clamp(sum[0], -ONE, ONE);
		ig = clamp((sum[1] >>> 2) + ONE / 2, 0, ONE);
		fg = clamp((sum[2] >>> 2) + ONE / 2, 0, ONE);
		og = clamp((sum[3] >>> 2) + ONE / 2, 0, ONE);
		exp_c = clamp(floor_mul(a, ig) + floor_mul(fg, c_m), -32768, 32767);
		exp_h = floor_mul(og, clamp(exp_c, -ONE, ONE));
		c_m = exp_c;
		h_m = exp_h;
	endtask

	task automatic compare_outputs();
		if (longint'(i_c) == exp_c && longint'(i_h) == exp_h)
		begin
			o_pass_cnt++;
			$display("step %0d ok: c %0d h %0d", step_no, i_c, i_h);
		end
		else
		begin
			o_fail_cnt++;
			$display("CHECK FAILED at %0t: step %0d c %0d expected %0d, h %0d expected %0d",
				$time, step_no, i_c, exp_c, i_h, exp_h);
		end
	endtask

	////////////////////
	// port monitor
	////////////////////

	always @(posedge i_clk)
	begin
		if (i_rst)
		begin
			busy = 1'b0;
			n_x = 0;
			wait_cnt = 0;
			step_no = 0;
			c_m = 0;
			h_m = 0;
			o_pass_cnt = 0;
			o_fail_cnt = 0;
		end
		else
		begin
			if (busy)
			begin
				wait_cnt--;
				if (wait_cnt == 0)
				begin
					busy = 1'b0;
					if (i_h_valid)
						compare_outputs();
					else
					begin
						o_fail_cnt++;
						$display("%0t: step %0d gave no o_h_valid %0d cycles after its last sample",
							$time, step_no, LATENCY);
					end
				end
				else if (i_h_valid)
				begin
					o_fail_cnt++;
					$display("%0t: step %0d raised o_h_valid too early", $time, step_no);
				end
			end
			else if (i_h_valid)
			begin
				o_fail_cnt++;
				$display("%0t: o_h_valid raised with no step in flight", $time);
			end
			if (i_wr && i_wr_addr < ENTRIES)
				wm[int'(i_wr_gate)][i_wr_addr] = longint'(i_wr_data);
			// new sequence, carried state back to zero
			if (i_seq_start)
			begin
				c_m = 0;
				h_m = 0;
			end
			if (i_x_valid)
			begin
				if (n_x < `LSTM_NUM_IN)
				begin
					xs[n_x] = longint'(i_x);
					n_x++;
				end
				if (i_x_last)
				begin
					step_no++;
					predict_step();
					n_x = 0;
					busy = 1'b1;
					wait_cnt = LATENCY;
				end
			end
		end
	end

endmodule

//--- bench/tb_lstm.sv
// lstm testbench top with clock, reset, stimulus table, weight loading and watchdog
`timescale 1ns/10ps
`include "lstm_macros.svh"

module tb_lstm
	import lstm_pkg::*;
	();

	localparam int ENTRIES = `LSTM_NUM_IN + 2;
	localparam int NROWS = 7;
	localparam int CLK_PERIOD = 40;
	localparam int STEP_WAIT = 20;

	// one stimulus row, x[k] is table sample k
	typedef struct packed {
		logic [1:0]       wset;
		logic [3:0]       steps;
		logic             new_seq;
		logic             gap;
		logic             rnd;
		logic [3:0][15:0] x;
	} row_t;

	logic clk;
	logic rst;
	logic seq_start;
	logic wr;
	gate_e wr_gate;
	logic [`LSTM_ADDR_WIDTH-1:0] wr_addr;
	fix_t wr_data;
	logic x_valid;
	logic x_last;
	fix_t x;
	logic h_valid;
	fix_t c_out;
	fix_t h_out;
	int pass_cnt;
	int fail_cnt;

	row_t table_rows [NROWS];
	fix_t wsets [3][4][ENTRIES];
	integer seed;
	int tb_errors;
	int total_steps;
	int loaded;
	int fails;

	lstm_top DUT (
		.i_clk       (clk),
		.i_rst       (rst),
		.i_seq_start (seq_start),
		.i_wr        (wr),
		.i_wr_gate   (wr_gate),
		.i_wr_addr   (wr_addr),
		.i_wr_data   (wr_data),
		.i_x_valid   (x_valid),
		.i_x_last    (x_last),
		.i_x         (x),
		.o_h_valid   (h_valid),
		.o_c         (c_out),
		.o_h         (h_out)
	);

	lstm_checker u_checker (
		.i_clk       (clk),
		.i_rst       (rst),
		.i_seq_start (seq_start),
		.i_wr        (wr),
		.i_wr_gate   (wr_gate),
		.i_wr_addr   (wr_addr),
		.i_wr_data   (wr_data),
		.i_x_valid   (x_valid),
		.i_x_last    (x_last),
		.i_x         (x),
		.i_h_valid   (h_valid),
		.i_c         (c_out),
		.i_h         (h_out),
		.o_pass_cnt  (pass_cnt),
		.o_fail_cnt  (fail_cnt)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////
	// stimulus table
	////////////////////

	task automatic fill_table();
		// wset, steps, new_seq, gap, rnd, samples x[3]..x[0]
		table_rows[0] = '{2'd0, 4'd1, 1'b1, 1'b0, 1'b0, {16'h0400, 16'hf000, 16'h1000, 16'h0800}};
		// large samples drive tanh and both sigmoid limits
		table_rows[1] = '{2'd1, 4'd1, 1'b1, 1'b0, 1'b0, {16'h7000, 16'h9000, 16'h6800, 16'h7800}};
		table_rows[2] = '{2'd1, 4'd3, 1'b1, 1'b0, 1'b0, {16'hf800, 16'h0a00, 16'hfccd, 16'h0333}};
		// same as row 2 after a restart
		table_rows[3] = '{2'd1, 4'd1, 1'b1, 1'b0, 1'b0, {16'hf800, 16'h0a00, 16'hfccd, 16'h0333}};
		table_rows[4] = '{2'd1, 4'd2, 1'b0, 1'b1, 1'b0, {16'h0600, 16'hf400, 16'h0c00, 16'h0200}};
		table_rows[5] = '{2'd2, 4'd4, 1'b1, 1'b0, 1'b1, 64'h0};
		table_rows[6] = '{2'd2, 4'd3, 1'b0, 1'b1, 1'b1, 64'h0};
	endtask

	task automatic fill_weight_sets();
		for (int g = 0; g < 4; g++)
		begin
			for (int a = 0; a < ENTRIES; a++)
			begin
				wsets[0][g][a] = '0;
				// steps of about 0.1 over gate and address
				wsets[1][g][a] = fix_t'(((g * 3 + a * 5) % 11 - 5) * 410);
				wsets[2][g][a] = fix_t'($random(seed) % 4096);
			end
		end
		// biases only, a 0.5, i 1.0, f -1.0, o 2.0
		wsets[0][GATE_A][ENTRIES-1] = 16'sd2048;
		wsets[0][GATE_I][ENTRIES-1] = 16'sd4096;
		wsets[0][GATE_F][ENTRIES-1] = -16'sd4096;
		wsets[0][GATE_O][ENTRIES-1] = 16'sd8192;
	endtask

	////////////////////
	// drivers
	////////////////////

	task automatic load_weights(input int set);
		for (int g = 0; g < 4; g++)
		begin
			for (int a = 0; a < ENTRIES; a++)
			begin
				@(posedge clk);
				#2;
				wr = 1'b1;
				wr_gate = gate_e'(g);
				wr_addr = (`LSTM_ADDR_WIDTH)'(a);
				wr_data = wsets[set][g][a];
			end
		end
		@(posedge clk);
		#2;
		wr = 1'b0;
	endtask

	task automatic start_sequence();
		@(posedge clk);
		#2;
		seq_start = 1'b1;
		@(posedge clk);
		#2;
		seq_start = 1'b0;
	endtask

	task automatic run_step(input int r);
		fix_t sample;
		int waited;
		for (int k = 0; k < `LSTM_NUM_IN; k++)
		begin
			if (table_rows[r].rnd)
				sample = fix_t'($random(seed) % 8192);
			else
				sample = fix_t'(table_rows[r].x[k % 4]);
			@(posedge clk);
			#2;
			x_valid = 1'b1;
			x_last = (k == `LSTM_NUM_IN - 1);
			x = sample;
			if (table_rows[r].gap && k != `LSTM_NUM_IN - 1)
			begin
				// idle cycle between samples
				@(posedge clk);
				#2;
				x_valid = 1'b0;
				x_last = 1'b0;
			end
		end
		@(posedge clk);
		#2;
		x_valid = 1'b0;
		x_last = 1'b0;
		waited = 0;
		while (!h_valid && waited < STEP_WAIT)
		begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (!h_valid)
		begin
			tb_errors++;
			$display("row %0d: no o_h_valid within %0d cycles of the last sample", r, STEP_WAIT);
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		seq_start = 1'b0;
		wr = 1'b0;
		wr_gate = GATE_A;
		wr_addr = '0;
		wr_data = '0;
		x_valid = 1'b0;
		x_last = 1'b0;
		x = '0;
		seed = 32'hef05_fdc4;
		tb_errors = 0;
		total_steps = 0;
		loaded = -1;
		fill_table();
		fill_weight_sets();
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int r = 0; r < NROWS; r++)
		begin
			if (int'(table_rows[r].wset) != loaded)
			begin
				load_weights(int'(table_rows[r].wset));
				loaded = int'(table_rows[r].wset);
			end
			if (table_rows[r].new_seq)
				start_sequence();
			for (int s = 0; s < int'(table_rows[r].steps); s++)
			begin
				run_step(r);
				total_steps++;
			end
		end
		repeat (5) @(posedge clk);
		fails = fail_cnt + tb_errors;
		$display("steps passed %0d failed %0d of %0d", pass_cnt, fails, total_steps);
		if (fails == 0 && pass_cnt == total_steps)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// limit from the table length, counted once reset is released
	initial
	begin
		int limit;
		limit = 1000;
		@(negedge rst);
		for (int r = 0; r < NROWS; r++)
			limit = limit + int'(table_rows[r].steps) * (`LSTM_NUM_IN + 10);
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Something failed");
		$finish;
	end

endmodule

//--- src.f
+incdir+common
common/lstm_pkg.sv
common/lstm_elem_if.sv
hw/weight_bank.sv
lstm_core/gate_mac.sv
lstm_core/gate_activation.sv
lstm_core/cell_update.sv
hw/lstm_top.sv
bench/lstm_checker.sv
bench/tb_lstm.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the lstm cell testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_lstm -f src.f -o tb_lstm_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

sim_output=$(./obj_dir/tb_lstm_sim)
status=$?
echo "$sim_output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" <<< "$sim_output"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
